// ==== src/walksat_defs.svh ====
//**************************************************************************
// walksat sizing and tuning macros shared by the RTL and the testbench
//**************************************************************************

`ifndef WALKSAT_DEFS_SVH
`define WALKSAT_DEFS_SVH

// literals per clause
`define NSAT            3

// variable space
`define NUM_VARS        64
`define VAR_BITS        6

// occurrence entries checked per literal lookup
`define MAX_OCC         8

// clause table geometry
`define CT_ROWS         32
`define CT_ADDR_BITS    5

// xorshift reset state, must not be zero
`define PRNG_SEED       32'h2545_f491

// noise path taken when prng top byte is below this value
`define NOISE_THRESHOLD 8'd48

`endif

// ==== src/walksat_pkg.sv ====
//**************************************************************************
// walksat types: literals, clause table rows, load words and step results
//**************************************************************************

`include "walksat_defs.svh"

package walksat_pkg;

    // width of one clause table row, also the width of a load data word
    localparam int CT_ROW_BITS  = 2 * `MAX_OCC * (`VAR_BITS + 1);
    // unused upper bits of a translation table entry
    localparam int ATT_PAD_BITS = CT_ROW_BITS - `MAX_OCC - `CT_ADDR_BITS;

    // neg = 1 means the literal holds when the variable is 0
    typedef struct packed {
        logic                 neg;
        logic [`VAR_BITS-1:0] vaddr;
    } literal_t;

    typedef struct packed {
        literal_t [`NSAT-1:0] lit;
    } clause_t;

    // the other two literals of a clause holding the looked-up literal
    typedef struct packed {
        literal_t [1:0] lit;
    } occ_entry_t;

    typedef struct packed {
        occ_entry_t [`MAX_OCC-1:0] entry;
    } ct_row_t;

    typedef struct packed {
        logic [ATT_PAD_BITS-1:0]  pad;
        logic [`MAX_OCC-1:0]      mask;
        logic [`CT_ADDR_BITS-1:0] row;
    } att_entry_t;

    // same load word, decoded by the load target bit
    typedef union packed {
        ct_row_t    ct;
        att_entry_t att;
    } load_word_u;

    // target 0 writes the translation table, 1 the clause table
    typedef struct packed {
        logic                 target;
        logic [`VAR_BITS:0]   addr;
        load_word_u           data;
    } load_cmd_t;

    typedef logic [1:0] cand_idx_t;
    typedef logic [3:0] count_t;

    typedef struct packed {
        cand_idx_t idx;
        literal_t  lit;
        count_t    count;
        logic      noise;
    } step_result_t;

endpackage

// ==== src/occurrence_table.sv ====
//**************************************************************************
// occurrence lookup: literal -> translation entry -> clause table row
//**************************************************************************

`include "walksat_defs.svh"

module occurrence_table
    import walksat_pkg::*;
(
    input  logic                clk_i,
    input  logic                load_valid_i,
    input  load_cmd_t           load_cmd_i,
    input  literal_t            lookup_lit_i,
    output ct_row_t             row_o,
    output logic [`MAX_OCC-1:0] mask_o
);

    localparam int ATT_DEPTH = 2 ** (`VAR_BITS + 1);

    // translation table, one entry per literal
    logic [`CT_ADDR_BITS-1:0] att_row  [ATT_DEPTH];
    logic [`MAX_OCC-1:0]      att_mask [ATT_DEPTH];

    // clause table rows
    ct_row_t ct_mem [`CT_ROWS];

    // combinational translation of the requested literal
    logic [`CT_ADDR_BITS-1:0] lk_row;
    logic [`MAX_OCC-1:0]      lk_mask;

    // clause table writes use only the low row address bits
    logic [`CT_ADDR_BITS-1:0] ld_ct_addr;

    assign ld_ct_addr = load_cmd_i.addr[`CT_ADDR_BITS-1:0];

    // load path
    // the target bit picks the table and the union view of the data word
    always_ff @(posedge clk_i) begin
        if (load_valid_i) begin
            if (load_cmd_i.target) begin
                ct_mem[ld_ct_addr] <= load_cmd_i.data.ct;
            end else begin
                att_row[load_cmd_i.addr]  <= load_cmd_i.data.att.row;
                att_mask[load_cmd_i.addr] <= load_cmd_i.data.att.mask;
            end
        end
    end

    // literal is used directly as the table index
    assign lk_row  = att_row[lookup_lit_i];
    assign lk_mask = att_mask[lookup_lit_i];

    // one cycle lookup
    // row and mask come out together on the next edge
    always_ff @(posedge clk_i) begin
        row_o  <= ct_mem[lk_row];
        mask_o <= lk_mask;
    end

endmodule

// ==== src/variable_table.sv ====
//**************************************************************************
// variable assignment bits with parallel read ports and one flip port
//**************************************************************************

`include "walksat_defs.svh"

module variable_table (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic [2*`MAX_OCC-1:0][`VAR_BITS-1:0]   rd_addr_i,
    output logic [2*`MAX_OCC-1:0]                  rd_val_o,
    input  logic                                   flip_i,
    input  logic [`VAR_BITS-1:0]                   flip_var_i
);

    // current assignment, all variables start at 0
    logic [`NUM_VARS-1:0] assign_q;

    // single write port
    // a flip just inverts the addressed bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            assign_q <= '0;
        end else if (flip_i) begin
            assign_q[flip_var_i] <= ~assign_q[flip_var_i];
        end
    end

    // one read port per occurrence literal, all combinational
    always_comb begin
        for (int p = 0; p < 2 * `MAX_OCC; p++) begin
            rd_val_o[p] = assign_q[rd_addr_i[p]];
        end
    end

endmodule

// ==== src/break_evaluator.sv ====
//**************************************************************************
// break count of one occurrence row, stored per candidate literal
//**************************************************************************

`include "walksat_defs.svh"

module break_evaluator
    import walksat_pkg::*;
(
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  ct_row_t                               row_i,
    input  logic [`MAX_OCC-1:0]                   mask_i,
    input  logic [2*`MAX_OCC-1:0]                 var_val_i,
    output logic [2*`MAX_OCC-1:0][`VAR_BITS-1:0]  var_addr_o,
    input  logic                                  cand_valid_i,
    input  cand_idx_t                             cand_idx_i,
    output count_t [`NSAT-1:0]                    counts_o
);

    // truth value of every occurrence literal
    logic [2*`MAX_OCC-1:0] lit_true;
    // entries that lose their only true literal
    logic [`MAX_OCC-1:0]   broken;
    count_t                broken_sum;

    // fan the row's variable addresses out to the variable table,
    // then compare each returned value with its negation bit
    always_comb begin
        for (int e = 0; e < `MAX_OCC; e++) begin
            for (int j = 0; j < 2; j++) begin
                var_addr_o[2*e+j] = row_i.entry[e].lit[j].vaddr;
                lit_true[2*e+j]   = var_val_i[2*e+j] != row_i.entry[e].lit[j].neg;
            end
        end
    end

    // masked-off entries never count
    always_comb begin
        for (int e = 0; e < `MAX_OCC; e++) begin
            broken[e] = mask_i[e] & ~lit_true[2*e] & ~lit_true[2*e+1];
        end
    end

    // population count of broken entries
    always_comb begin
        broken_sum = '0;
        for (int e = 0; e < `MAX_OCC; e++) begin
            broken_sum = broken_sum + count_t'(broken[e]);
        end
    end

    // count slot per candidate, written in the evaluate cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            counts_o <= '0;
        end else if (cand_valid_i && (cand_idx_i < `NSAT)) begin
            counts_o[cand_idx_i] <= broken_sum;
        end
    end

endmodule

// ==== src/flip_selector.sv ====
//**************************************************************************
// flip choice: greedy minimum break count or xorshift noise pick
//**************************************************************************

`include "walksat_defs.svh"

module flip_selector
    import walksat_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               select_i,
    input  clause_t            clause_i,
    input  count_t [`NSAT-1:0] counts_i,
    output step_result_t       result_o
);

    logic [31:0] prng_q;
    logic [31:0] prng_next;

    cand_idx_t   best_idx;
    count_t      best_cnt;
    logic        noise_hit;
    cand_idx_t   pick_idx;

    // xorshift32, shifts 13/17/5
    always_comb begin
        logic [31:0] x;
        x = prng_q;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        prng_next = x;
    end

    // advances only on a select strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prng_q <= `PRNG_SEED;
        end else if (select_i) begin
            prng_q <= prng_next;
        end
    end

    // strict compare keeps the lowest index on ties
    always_comb begin
        best_idx = '0;
        best_cnt = counts_i[0];
        for (int k = 1; k < `NSAT; k++) begin
            if (counts_i[k] < best_cnt) begin
                best_idx = cand_idx_t'(k);
                best_cnt = counts_i[k];
            end
        end
    end

    // noise uses the fresh prng word
    // low bits equal to 3 name no literal, fall back to greedy
    assign noise_hit = (prng_next[31:24] < `NOISE_THRESHOLD) && (prng_next[1:0] != 2'd3);
    assign pick_idx  = noise_hit ? prng_next[1:0] : best_idx;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
        end else if (select_i) begin
            result_o.idx   <= pick_idx;
            result_o.lit   <= clause_i.lit[pick_idx];
            result_o.count <= counts_i[pick_idx];
            result_o.noise <= noise_hit;
        end
    end

endmodule

// ==== src/step_sequencer.sv ====
//**************************************************************************
// step control: req/ack handshake and per-candidate lookup schedule
//**************************************************************************

`include "walksat_defs.svh"

module step_sequencer
    import walksat_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  clause_t              clause_i,
    input  step_result_t         result_i,
    output logic                 ack_o,
    output literal_t             lookup_lit_o,
    output logic                 cand_valid_o,
    output cand_idx_t            cand_idx_o,
    output logic                 select_o,
    output logic                 flip_o,
    output logic [`VAR_BITS-1:0] flip_var_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_EVAL,
        S_SELECT,
        S_ACK,
        S_WAIT
    } state_t;

    state_t    state_q;
    state_t    state_d;
    cand_idx_t idx_q;
    clause_t   clause_q;
    logic      ack_q;
    literal_t  cand_lit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // a new step only once the previous ack has dropped
            S_IDLE:   if (req_i && !ack_q) state_d = S_LOOKUP;
            S_LOOKUP: state_d = S_EVAL;
            S_EVAL:   state_d = (idx_q == cand_idx_t'(`NSAT - 1)) ? S_SELECT : S_LOOKUP;
            S_SELECT: state_d = S_ACK;
            S_ACK:    state_d = S_WAIT;
            // requester holds req_i high to stall here
            S_WAIT:   if (!req_i) state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    // ack lags the ack/wait states by one edge
    // rises with the flip write, falls one edge after req_i is seen low
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= (state_q == S_ACK) || (state_q == S_WAIT);
            if (state_q == S_IDLE) begin
                idx_q <= '0;
            end else if (state_q == S_EVAL) begin
                idx_q <= (idx_q == cand_idx_t'(`NSAT - 1)) ? '0 : idx_q + 1'b1;
            end
        end
    end

    // clause held for the whole step
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && req_i) begin
            clause_q <= clause_i;
        end
    end

    // flipping a false literal breaks clauses holding its true opposite,
    // so the lookup goes to the negated literal
    assign cand_lit     = clause_q.lit[idx_q];
    assign lookup_lit_o = '{neg: ~cand_lit.neg, vaddr: cand_lit.vaddr};

    assign cand_valid_o = (state_q == S_EVAL);
    assign cand_idx_o   = idx_q;
    assign select_o     = (state_q == S_SELECT);

    // exactly one flip per step, from the registered selection
    assign flip_o     = (state_q == S_ACK);
    assign flip_var_o = result_i.lit.vaddr;

    assign ack_o = ack_q;

endmodule

// ==== src/walksat_datapath.sv ====
//**************************************************************************
// walksat flip step datapath top: tables, break counts, selection, flip
//**************************************************************************

`include "walksat_defs.svh"

module walksat_datapath
    import walksat_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         load_valid_i,
    input  load_cmd_t    load_cmd_i,
    input  logic         req_i,
    input  clause_t      clause_i,
    output logic         ack_o,
    output step_result_t result_o
);

    // sequencer controls
    literal_t             seq_lookup_lit;
    logic                 seq_cand_valid;
    cand_idx_t            seq_cand_idx;
    logic                 seq_select;
    logic                 seq_flip;
    logic [`VAR_BITS-1:0] seq_flip_var;

    // occurrence row for the current candidate
    ct_row_t              ot_row;
    logic [`MAX_OCC-1:0]  ot_mask;

    // variable table read ports
    logic [2*`MAX_OCC-1:0][`VAR_BITS-1:0] be_var_addr;
    logic [2*`MAX_OCC-1:0]                vt_var_val;

    count_t [`NSAT-1:0]   be_counts;

    step_sequencer u_step_sequencer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .clause_i     (clause_i),
        .result_i     (result_o),
        .ack_o        (ack_o),
        .lookup_lit_o (seq_lookup_lit),
        .cand_valid_o (seq_cand_valid),
        .cand_idx_o   (seq_cand_idx),
        .select_o     (seq_select),
        .flip_o       (seq_flip),
        .flip_var_o   (seq_flip_var)
    );

    occurrence_table u_occurrence_table (
        .clk_i        (clk_i),
        .load_valid_i (load_valid_i),
        .load_cmd_i   (load_cmd_i),
        .lookup_lit_i (seq_lookup_lit),
        .row_o        (ot_row),
        .mask_o       (ot_mask)
    );

    variable_table u_variable_table (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_addr_i  (be_var_addr),
        .rd_val_o   (vt_var_val),
        .flip_i     (seq_flip),
        .flip_var_i (seq_flip_var)
    );

    break_evaluator u_break_evaluator (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .row_i        (ot_row),
        .mask_i       (ot_mask),
        .var_val_i    (vt_var_val),
        .var_addr_o   (be_var_addr),
        .cand_valid_i (seq_cand_valid),
        .cand_idx_i   (seq_cand_idx),
        .counts_o     (be_counts)
    );

    // clause_i stays stable while req_i is high, so it feeds the selector
    flip_selector u_flip_selector (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .select_i (seq_select),
        .clause_i (clause_i),
        .counts_i (be_counts),
        .result_o (result_o)
    );

endmodule

// ==== tb/walksat_checker.sv ====
//**************************************************************************
// walksat step handshake assertions, bound into the datapath top
//**************************************************************************

module walksat_checker
    import walksat_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         req_i,
    input  logic         ack_i,
    input  step_result_t result_i
);

    // failed assertions, read by the testbench
    int fails = 0;

    // ack only answers a request that is already up
    ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose while no request was pending");
            fails++;
        end

    // ack only drops once the request is gone
    ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            $error("ack fell while the request was still high");
            fails++;
        end

    result_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |-> $stable(result_i))
        else begin
            $error("result changed while ack was high");
            fails++;
        end

    // reset clears the handshake and the result
    reset_clear: assert property (@(posedge clk_i)
        rst_i |=> (!ack_i && result_i == '0))
        else begin
            $error("ack or result not cleared by reset");
            fails++;
        end

endmodule

// ==== tb/walksat_tb.sv ====
//**************************************************************************
// walksat datapath testbench: directed flip steps checked against a table model
//**************************************************************************

`include "walksat_defs.svh"

module walksat_tb
    import walksat_pkg::*;
();

    // step count over all tests, and cycles spent on table loads
    localparam int MAX_STEPS   = 68;
    localparam int LOAD_CYCLES = 128 + `CT_ROWS + 16;
    localparam int TIMEOUT     = 4 * (8 + LOAD_CYCLES + 40 * MAX_STEPS);

    logic         clk;
    logic         rst;
    logic         load_valid;
    load_cmd_t    load_cmd;
    logic         req;
    clause_t      clause;
    logic         ack;
    step_result_t result;

    // model of tables, assignment and xorshift state
    logic [`CT_ADDR_BITS-1:0] m_att_row  [128];
    logic [`MAX_OCC-1:0]      m_att_mask [128];
    ct_row_t                  m_ct       [`CT_ROWS];
    logic [`NUM_VARS-1:0]     m_assign;
    logic [31:0]              m_prng;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    walksat_datapath u_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .load_valid_i (load_valid),
        .load_cmd_i   (load_cmd),
        .req_i        (req),
        .clause_i     (clause),
        .ack_o        (ack),
        .result_o     (result)
    );

    bind walksat_datapath walksat_checker u_checker (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .ack_i    (ack_o),
        .result_i (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("[ERROR] watchdog: run did not finish within %0d time units", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    function automatic literal_t make_lit(input logic neg, input logic [`VAR_BITS-1:0] v);
        literal_t l;
        l.neg   = neg;
        l.vaddr = v;
        return l;
    endfunction

    function automatic clause_t make_clause(input literal_t a, input literal_t b,
                                            input literal_t c);
        clause_t cl;
        cl.lit[0] = a;
        cl.lit[1] = b;
        cl.lit[2] = c;
        return cl;
    endfunction

    // every entry of the row holds the same literal pair
    function automatic ct_row_t same_pair_row(input literal_t a, input literal_t b);
        ct_row_t r;
        for (int e = 0; e < `MAX_OCC; e++) begin
            r.entry[e].lit[0] = a;
            r.entry[e].lit[1] = b;
        end
        return r;
    endfunction

    // background rows, the pattern uses the whole row address
    function automatic ct_row_t fill_pattern(input int r);
        ct_row_t row;
        for (int e = 0; e < `MAX_OCC; e++) begin
            for (int j = 0; j < 2; j++) begin
                row.entry[e].lit[j].neg   = 1'((r + e + j) % 2);
                row.entry[e].lit[j].vaddr = 6'(r * 7 + e * 2 + j);
            end
        end
        return row;
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // breaks when flipping cand: masked entries of the opposite literal's row
    // in which both literals are false
    function automatic count_t model_count(input literal_t cand);
        logic [6:0] lk;
        ct_row_t    row;
        count_t     n;
        logic       t0;
        logic       t1;
        lk  = {~cand.neg, cand.vaddr};
        row = m_ct[m_att_row[lk]];
        n   = '0;
        for (int e = 0; e < `MAX_OCC; e++) begin
            t0 = m_assign[row.entry[e].lit[0].vaddr] != row.entry[e].lit[0].neg;
            t1 = m_assign[row.entry[e].lit[1].vaddr] != row.entry[e].lit[1].neg;
            if (m_att_mask[lk][e] && !t0 && !t1) begin
                n = n + 4'd1;
            end
        end
        return n;
    endfunction

    // expected result of one step, then the model flips the chosen variable
    function automatic step_result_t model_step(input clause_t c);
        count_t       cnt [3];
        logic [31:0]  x;
        cand_idx_t    k;
        step_result_t r;
        for (int i = 0; i < 3; i++) begin
            cnt[i] = model_count(c.lit[i]);
        end
        x      = m_prng;
        x      = x ^ (x << 13);
        x      = x ^ (x >> 17);
        x      = x ^ (x << 5);
        m_prng = x;
        k      = '0;
        r.noise = (x[31:24] < `NOISE_THRESHOLD) && (x[1:0] != 2'd3);
        if (r.noise) begin
            k = x[1:0];
        end else begin
            for (int i = 1; i < 3; i++) begin
                if (cnt[i] < cnt[k]) k = cand_idx_t'(i);
            end
        end
        r.idx   = k;
        r.lit   = c.lit[k];
        r.count = cnt[k];
        m_assign[r.lit.vaddr] = ~m_assign[r.lit.vaddr];
        return r;
    endfunction

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_result(input string name, input step_result_t exp,
                                  input step_result_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected idx=%0d lit=%h count=%0d noise=%b",
                     name, exp.idx, exp.lit, exp.count, exp.noise);
            $display("[ERROR] %s: actual   idx=%0d lit=%h count=%0d noise=%b",
                     name, act.idx, act.lit, act.count, act.noise);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s: expected %0d edges, actual %0d", name, exp, act);
        end
    endtask

    // one table write, the model follows the same target decode
    task automatic load_word(input logic tgt, input logic [6:0] addr, input load_word_u w);
        load_valid      = 1'b1;
        load_cmd.target = tgt;
        load_cmd.addr   = addr;
        load_cmd.data   = w;
        if (tgt) begin
            m_ct[addr[`CT_ADDR_BITS-1:0]] = w.ct;
        end else begin
            m_att_row[addr]  = w.att.row;
            m_att_mask[addr] = w.att.mask;
        end
        @(posedge clk);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic map_lit(input literal_t l, input logic [4:0] row, input logic [7:0] mask);
        load_word_u w;
        w          = '0;
        w.att.row  = row;
        w.att.mask = mask;
        load_word(1'b0, l, w);
    endtask

    task automatic load_row(input logic [4:0] row, input literal_t a, input literal_t b);
        load_word_u w;
        w.ct = same_pair_row(a, b);
        load_word(1'b1, {2'b00, row}, w);
    endtask

    // every literal maps to an empty mask until a test remaps it
    task automatic load_defaults();
        load_word_u w;
        for (int l = 0; l < 128; l++) begin
            map_lit(literal_t'(l), 5'd0, 8'h00);
        end
        for (int r = 0; r < `CT_ROWS; r++) begin
            w.ct = fill_pattern(r);
            load_word(1'b1, 7'(r), w);
        end
    endtask

    // full four-phase step; hold keeps req up a few cycles past ack
    task automatic run_step(input string name, input clause_t c, input logic hold,
                            output logic noise);
        step_result_t exp;
        int           n;
        exp    = model_step(c);
        noise  = exp.noise;
        clause = c;
        req    = 1'b1;
        n      = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ack && n < 20);
        if (!ack) begin
            errors++;
            $display("[ERROR] %s: no ack within 20 cycles of the request", name);
            req = 1'b0;
            return;
        end
        // first sampling edge plus 8 cycles
        check_latency({name, " ack latency"}, 9, n);
        compare_result(name, exp, result);
        if (hold) begin
            repeat (3) begin
                @(posedge clk);
                #1;
                compare_bit({name, " held ack"}, 1'b1, ack);
                compare_result({name, " held result"}, exp, result);
            end
        end
        req = 1'b0;
        n   = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (ack && n < 5);
        if (ack) begin
            errors++;
            $display("[ERROR] %s: ack still high 5 cycles after req dropped", name);
        end else begin
            check_latency({name, " ack release"}, 2, n);
        end
    endtask

    task automatic test_reset();
        compare_bit("reset ack", 1'b0, ack);
        compare_result("reset result", '0, result);
    endtask

    // row 1 is all false under the zero assignment, masks set the counts 5 2 4
    task automatic test_greedy();
        logic noise;
        load_row(5'd1, make_lit(1'b0, 6'd40), make_lit(1'b0, 6'd41));
        map_lit(make_lit(1'b1, 6'd1), 5'd1, 8'h1f);
        map_lit(make_lit(1'b0, 6'd2), 5'd1, 8'h05);
        map_lit(make_lit(1'b1, 6'd3), 5'd1, 8'hf0);
        run_step("greedy", make_clause(make_lit(1'b0, 6'd1), make_lit(1'b1, 6'd2),
                 make_lit(1'b0, 6'd3)), 1'b0, noise);
    endtask

    // counts 8 0 0, the two masked-off rows tie at zero
    task automatic test_ties();
        logic noise;
        map_lit(make_lit(1'b1, 6'd4), 5'd1, 8'hff);
        map_lit(make_lit(1'b1, 6'd5), 5'd1, 8'h00);
        map_lit(make_lit(1'b1, 6'd6), 5'd1, 8'h00);
        run_step("ties", make_clause(make_lit(1'b0, 6'd4), make_lit(1'b0, 6'd5),
                 make_lit(1'b0, 6'd6)), 1'b0, noise);
    endtask

    // first step flips v8 under a held req, the second reads v8 back
    task automatic test_flip();
        logic noise;
        load_row(5'd2, make_lit(1'b0, 6'd8), make_lit(1'b0, 6'd50));
        load_row(5'd3, make_lit(1'b1, 6'd8), make_lit(1'b0, 6'd51));
        map_lit(make_lit(1'b1, 6'd8), 5'd1, 8'h00);
        map_lit(make_lit(1'b1, 6'd9), 5'd1, 8'h07);
        map_lit(make_lit(1'b1, 6'd10), 5'd1, 8'h07);
        map_lit(make_lit(1'b1, 6'd11), 5'd2, 8'hff);
        map_lit(make_lit(1'b1, 6'd12), 5'd3, 8'h07);
        map_lit(make_lit(1'b1, 6'd13), 5'd3, 8'h01);
        run_step("flip first", make_clause(make_lit(1'b0, 6'd8), make_lit(1'b0, 6'd9),
                 make_lit(1'b0, 6'd10)), 1'b1, noise);
        run_step("flip second", make_clause(make_lit(1'b0, 6'd11), make_lit(1'b0, 6'd12),
                 make_lit(1'b0, 6'd13)), 1'b0, noise);
    endtask

    // random clauses until the model has seen two noise steps
    task automatic test_noise();
        logic    noise;
        int      noise_seen;
        int      n;
        clause_t c;
        noise_seen = 0;
        n          = 0;
        while (noise_seen < 2 && n < 64) begin
            c = clause_t'(lfsr_take(21));
            run_step("noise", c, 1'b0, noise);
            if (noise) noise_seen++;
            n++;
        end
        if (noise_seen < 2) begin
            errors++;
            $display("[ERROR] noise: model predicted fewer than 2 noise steps in 64");
        end
    endtask

    initial begin
        rst        = 1'b1;
        load_valid = 1'b0;
        load_cmd   = '0;
        req        = 1'b0;
        clause     = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hf57a_ab04;
        m_prng     = `PRNG_SEED;
        m_assign   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        load_defaults();
        test_greedy();
        test_ties();
        test_flip();
        test_noise();
        $display("checks=%0d errors=%0d assertion_failures=%0d",
                 checks, errors, u_dut.u_checker.fails);
        if (errors == 0 && u_dut.u_checker.fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== walksat_datapath.f ====
+incdir+src
src/walksat_pkg.sv
src/occurrence_table.sv
src/variable_table.sv
src/break_evaluator.sv
src/flip_selector.sv
src/step_sequencer.sv
src/walksat_datapath.sv
tb/walksat_checker.sv
tb/walksat_tb.sv
